/* cpuControlPkg.sv */
package cpuControlPkg;

    typedef enum logic [3:0] {
        OpAnd  = 4'd0,
        OpOr   = 4'd1,
        OpNot  = 4'd2,
        OpAdd  = 4'd3,
        OpSub  = 4'd4,
        OpLsr  = 4'd5,
        OpLsl  = 4'd6,
        OpInc  = 4'd7,
        OpDec  = 4'd8,
        OpBra  = 4'd9,
        OpBne  = 4'd10,
        OpMov  = 4'd11,
        OpLd   = 4'd12,
        OpSt   = 4'd13,
        OpPull = 4'd14,
        OpPush = 4'd15
    } opcodeT;

    typedef enum logic [1:0] {
        StepFetchLow  = 2'b00,
        StepFetchHigh = 2'b01,
        StepExec1     = 2'b10,
        StepExec2     = 2'b11
    } stepT;

    typedef enum logic [3:0] {
        AluPassA = 4'b0000,
        AluPassB = 4'b0001,
        AluNot   = 4'b0010,
        AluAdd   = 4'b0100,
        AluSub   = 4'b0101,
        AluAnd   = 4'b0111,
        AluOr    = 4'b1000,
        AluLsl   = 4'b1011,
        AluLsr   = 4'b1100
    } aluFunT;

    typedef enum logic [1:0] {FunClear = 2'b00, FunLoad = 2'b01, FunDec = 2'b10, FunInc = 2'b11} regFunT;
    typedef enum logic [1:0] {MuxAAlu = 2'b00, MuxAMem = 2'b01, MuxAIrAddr = 2'b10} muxASelT;
    typedef enum logic [1:0] {MuxBAlu = 2'b00, MuxBArf = 2'b01, MuxBIrAddr = 2'b10, MuxBMem = 2'b11} muxBSelT;
    typedef enum logic [1:0] {ArfAr = 2'b00, ArfSp = 2'b01, ArfPc = 2'b11} arfOutT;

    typedef logic [3:0] regCodeT; // 0..3 R1..R4, 4 SP, 5 AR, 6/7 PC

    localparam regCodeT RegR1    = 4'd0;
    localparam regCodeT RegSp    = 4'd4;
    localparam regCodeT RegAr    = 4'd5;
    localparam regCodeT RegPcLow = 4'd6;
    localparam regCodeT RegPc    = 4'd7;

    // Instruction word fields
    localparam int OpcodeMsb = 15;
    localparam int OpcodeLsb = 12;
    localparam int DstMsb    = 11;
    localparam int DstLsb    = 8;
    localparam int SrcAMsb   = 7;
    localparam int SrcALsb   = 4;
    localparam int SrcBMsb   = 3;
    localparam int SrcBLsb   = 0;
    localparam int RSelMsb   = 9;
    localparam int RSelLsb   = 8;
    localparam int ModeBit   = 10; // 1 = direct

    localparam int ZeroFlagBit = 0;

    localparam logic [2:0] RfOutNone  = 3'b000;
    localparam logic [3:0] RfSelNone  = 4'b0000;
    localparam logic [3:0] ArfSelNone = 4'b0000;
    localparam logic [3:0] ArfSelSp   = 4'b0010;
    localparam logic [3:0] ArfSelAr   = 4'b0100;
    localparam logic [3:0] ArfSelPc   = 4'b1000;

endpackage

/* instructionDecoder.sv */
`timescale 1ns/1ps
module instructionDecoder (
    input  logic [15:0]           irOut,
    input  logic [3:0]            aluFlags,
    output cpuControlPkg::opcodeT  opcode,
    output cpuControlPkg::regCodeT dstReg,
    output cpuControlPkg::regCodeT srcA,
    output cpuControlPkg::regCodeT srcB,
    output logic [1:0]            rSel,
    output logic                  directMode,
    output logic                  zero
);

    logic isDropped;

    assign opcode = cpuControlPkg::opcodeT'(
        irOut[cpuControlPkg::OpcodeMsb:cpuControlPkg::OpcodeLsb]);

    // Stack and inc/dec opcodes are not executed here
    assign isDropped = (opcode == cpuControlPkg::OpInc) ||
                       (opcode == cpuControlPkg::OpDec) ||
                       (opcode == cpuControlPkg::OpPull) ||
                       (opcode == cpuControlPkg::OpPush);

    always_comb begin
        dstReg = irOut[cpuControlPkg::DstMsb:cpuControlPkg::DstLsb];
        srcA   = irOut[cpuControlPkg::SrcAMsb:cpuControlPkg::SrcALsb];
        srcB   = irOut[cpuControlPkg::SrcBMsb:cpuControlPkg::SrcBLsb];
        if (isDropped) begin
            dstReg = cpuControlPkg::RegR1; // Keep ARF paths quiet
            srcA   = cpuControlPkg::RegR1;
            srcB   = cpuControlPkg::RegR1;
        end
    end

    assign rSel       = irOut[cpuControlPkg::RSelMsb:cpuControlPkg::RSelLsb];
    assign directMode = irOut[cpuControlPkg::ModeBit];
    assign zero       = aluFlags[cpuControlPkg::ZeroFlagBit];

endmodule

/* registerSelect.sv */
`timescale 1ns/1ps
module registerSelect (
    input  cpuControlPkg::regCodeT srcA,
    input  cpuControlPkg::regCodeT srcB,
    input  cpuControlPkg::regCodeT dstReg,
    input  logic [1:0]            rSel,
    input  logic                  useRSel,
    output logic [2:0]            rfOutASel,
    output logic [2:0]            rfOutBSel,
    output cpuControlPkg::arfOutT  arfOutCSel,
    output logic                  muxCSel,
    output logic                  dstIsArf,
    output logic [3:0]            rfDestSel,
    output logic [3:0]            arfDestSel
);

    cpuControlPkg::regCodeT srcBEff;
    cpuControlPkg::regCodeT dstEff;

    function automatic logic isRf(cpuControlPkg::regCodeT code);
        return code[3:2] == 2'b00;
    endfunction

    function automatic logic isArf(cpuControlPkg::regCodeT code);
        return (code == cpuControlPkg::RegSp) || (code == cpuControlPkg::RegAr) ||
               (code == cpuControlPkg::RegPcLow) || (code == cpuControlPkg::RegPc);
    endfunction

    function automatic logic [2:0] rfReadSel(cpuControlPkg::regCodeT code);
        return isRf(code) ? {1'b1, code[1:0]} : cpuControlPkg::RfOutNone; // R1..R4 = 100..111
    endfunction

    // LD and ST name their RF register in the rSel field
    assign srcBEff = useRSel ? cpuControlPkg::regCodeT'({2'b00, rSel}) : srcB;
    assign dstEff  = useRSel ? cpuControlPkg::regCodeT'({2'b00, rSel}) : dstReg;

    assign rfOutASel = rfReadSel(srcA);
    assign rfOutBSel = rfReadSel(srcBEff);
    assign muxCSel   = isArf(srcA);
    assign dstIsArf  = isArf(dstEff);

    always_comb begin
        case (srcA)
            cpuControlPkg::RegSp:    arfOutCSel = cpuControlPkg::ArfSp;
            cpuControlPkg::RegPcLow,
            cpuControlPkg::RegPc:    arfOutCSel = cpuControlPkg::ArfPc;
            default:                 arfOutCSel = cpuControlPkg::ArfAr; // Also the idle value
        endcase
    end

    always_comb begin
        rfDestSel  = cpuControlPkg::RfSelNone;
        arfDestSel = cpuControlPkg::ArfSelNone;
        if (isRf(dstEff)) begin
            rfDestSel = 4'b1000 >> dstEff[1:0]; // R1 is the MSB
        end
        case (dstEff)
            cpuControlPkg::RegSp:    arfDestSel = cpuControlPkg::ArfSelSp;
            cpuControlPkg::RegAr:    arfDestSel = cpuControlPkg::ArfSelAr;
            cpuControlPkg::RegPcLow,
            cpuControlPkg::RegPc:    arfDestSel = cpuControlPkg::ArfSelPc;
            default:                 arfDestSel = cpuControlPkg::ArfSelNone;
        endcase
    end

endmodule

/* controlSequencer.sv */
`timescale 1ns/1ps
module controlSequencer (
    input  logic                  clock,
    input  logic                  rstN,
    input  cpuControlPkg::opcodeT  opcode,
    input  logic                  directMode,
    input  logic                  zero,
    input  logic                  dstIsArf,
    input  logic [3:0]            rfDestSel,
    input  logic [3:0]            arfDestSel,
    output logic                  useRSel,
    output cpuControlPkg::stepT    step,
    output cpuControlPkg::regFunT  rfFunSel,
    output cpuControlPkg::regFunT  arfFunSel,
    output cpuControlPkg::regFunT  irFunSel,
    output logic [3:0]            rfRSel,
    output logic [3:0]            arfRegSel,
    output cpuControlPkg::aluFunT  aluFunSel,
    output cpuControlPkg::arfOutT  arfOutDSel,
    output cpuControlPkg::muxASelT muxASel,
    output cpuControlPkg::muxBSelT muxBSel,
    output logic                  irLH,
    output logic                  irEnable,
    output logic                  memWrite
);

    cpuControlPkg::stepT   nextStep;
    cpuControlPkg::aluFunT opAluFun;
    logic isAluOp;
    logic takeBranch;
    logic needExec2;

    assign useRSel = (opcode == cpuControlPkg::OpLd) || (opcode == cpuControlPkg::OpSt);

    assign takeBranch = (opcode == cpuControlPkg::OpBra) ||
                        ((opcode == cpuControlPkg::OpBne) && !zero);

    // Direct modes fetch the operand through AR first
    assign needExec2 = (directMode && (takeBranch || opcode == cpuControlPkg::OpLd)) ||
                       (opcode == cpuControlPkg::OpSt);

    always_comb begin
        isAluOp  = 1'b1;
        opAluFun = cpuControlPkg::AluPassA;
        case (opcode)
            cpuControlPkg::OpAnd: opAluFun = cpuControlPkg::AluAnd;
            cpuControlPkg::OpOr:  opAluFun = cpuControlPkg::AluOr;
            cpuControlPkg::OpNot: opAluFun = cpuControlPkg::AluNot;
            cpuControlPkg::OpAdd: opAluFun = cpuControlPkg::AluAdd;
            cpuControlPkg::OpSub: opAluFun = cpuControlPkg::AluSub;
            cpuControlPkg::OpLsr: opAluFun = cpuControlPkg::AluLsr;
            cpuControlPkg::OpLsl: opAluFun = cpuControlPkg::AluLsl;
            cpuControlPkg::OpMov: opAluFun = cpuControlPkg::AluPassA;
            default:              isAluOp  = 1'b0;
        endcase
    end

    always_comb begin
        case (step)
            cpuControlPkg::StepFetchLow:  nextStep = cpuControlPkg::StepFetchHigh;
            cpuControlPkg::StepFetchHigh: nextStep = cpuControlPkg::StepExec1;
            cpuControlPkg::StepExec1:     nextStep = needExec2 ? cpuControlPkg::StepExec2
                                                               : cpuControlPkg::StepFetchLow;
            default:                      nextStep = cpuControlPkg::StepFetchLow;
        endcase
    end

    always_ff @(posedge clock or negedge rstN) begin
        if (!rstN) begin
            step <= cpuControlPkg::StepFetchLow;
        end else begin
            step <= nextStep;
        end
    end

    always_comb begin
        rfFunSel   = cpuControlPkg::FunLoad;
        arfFunSel  = cpuControlPkg::FunLoad;
        irFunSel   = cpuControlPkg::FunLoad;
        rfRSel     = cpuControlPkg::RfSelNone;
        arfRegSel  = cpuControlPkg::ArfSelNone;
        aluFunSel  = cpuControlPkg::AluPassA;
        arfOutDSel = cpuControlPkg::ArfPc;
        muxASel    = cpuControlPkg::MuxAAlu;
        muxBSel    = cpuControlPkg::MuxBAlu;
        irLH       = 1'b0;
        irEnable   = 1'b0;
        memWrite   = 1'b0;
        case (step)
            cpuControlPkg::StepFetchLow, cpuControlPkg::StepFetchHigh: begin
                irEnable  = 1'b1;
                irLH      = (step == cpuControlPkg::StepFetchHigh); // High byte second
                arfFunSel = cpuControlPkg::FunInc; // PC++
                arfRegSel = cpuControlPkg::ArfSelPc;
            end
            cpuControlPkg::StepExec1: begin
                if (isAluOp) begin
                    aluFunSel = opAluFun;
                    if (dstIsArf) begin
                        arfRegSel = arfDestSel;
                    end else begin
                        rfRSel = rfDestSel;
                    end
                end else if ((takeBranch || opcode == cpuControlPkg::OpLd) && !directMode) begin
                    if (takeBranch) begin
                        muxBSel   = cpuControlPkg::MuxBIrAddr;
                        arfRegSel = cpuControlPkg::ArfSelPc;
                    end else begin
                        muxASel = cpuControlPkg::MuxAIrAddr; // Immediate load
                        rfRSel  = rfDestSel;
                    end
                end else if (needExec2) begin
                    muxBSel   = cpuControlPkg::MuxBIrAddr; // AR <- address
                    arfRegSel = cpuControlPkg::ArfSelAr;
                end
            end
            default: begin
                arfOutDSel = cpuControlPkg::ArfAr; // Memory at AR
                if (opcode == cpuControlPkg::OpSt) begin
                    aluFunSel = cpuControlPkg::AluPassB;
                    memWrite  = 1'b1;
                end else if (opcode == cpuControlPkg::OpLd) begin
                    muxASel = cpuControlPkg::MuxAMem;
                    rfRSel  = rfDestSel;
                end else if (takeBranch) begin
                    muxBSel   = cpuControlPkg::MuxBMem;
                    arfRegSel = cpuControlPkg::ArfSelPc;
                end
            end
        endcase
    end

endmodule

/* cpuControl.sv */
`timescale 1ns/1ps
module cpuControl (
    input  logic                  clock,
    input  logic                  rstN,
    input  logic [15:0]           irOut,
    input  logic [3:0]            aluFlags,
    output logic [2:0]            rfOutASel,
    output logic [2:0]            rfOutBSel,
    output cpuControlPkg::regFunT  rfFunSel,
    output logic [3:0]            rfRSel,
    output cpuControlPkg::aluFunT  aluFunSel,
    output cpuControlPkg::arfOutT  arfOutCSel,
    output cpuControlPkg::arfOutT  arfOutDSel,
    output cpuControlPkg::regFunT  arfFunSel,
    output logic [3:0]            arfRegSel,
    output logic                  irLH,
    output logic                  irEnable,
    output cpuControlPkg::regFunT  irFunSel,
    output logic                  memWrite,
    output cpuControlPkg::muxASelT muxASel,
    output cpuControlPkg::muxBSelT muxBSel,
    output logic                  muxCSel
);

    cpuControlPkg::opcodeT  opcode;
    cpuControlPkg::regCodeT dstReg;
    cpuControlPkg::regCodeT srcA;
    cpuControlPkg::regCodeT srcB;
    logic [1:0] rSel;
    logic       directMode;
    logic       zero;
    logic       useRSel;
    logic       dstIsArf;
    logic [3:0] rfDestSel;
    logic [3:0] arfDestSel;

    instructionDecoder i_instructionDecoder (
        .irOut(irOut), .aluFlags(aluFlags), .opcode(opcode), .dstReg(dstReg),
        .srcA(srcA), .srcB(srcB), .rSel(rSel), .directMode(directMode), .zero(zero)
    );

    registerSelect i_registerSelect (
        .srcA(srcA), .srcB(srcB), .dstReg(dstReg), .rSel(rSel), .useRSel(useRSel),
        .rfOutASel(rfOutASel), .rfOutBSel(rfOutBSel), .arfOutCSel(arfOutCSel),
        .muxCSel(muxCSel), .dstIsArf(dstIsArf), .rfDestSel(rfDestSel),
        .arfDestSel(arfDestSel)
    );

    controlSequencer i_controlSequencer (
        .clock(clock), .rstN(rstN), .opcode(opcode), .directMode(directMode),
        .zero(zero), .dstIsArf(dstIsArf), .rfDestSel(rfDestSel), .arfDestSel(arfDestSel),
        .useRSel(useRSel), .step(), .rfFunSel(rfFunSel), .arfFunSel(arfFunSel),
        .irFunSel(irFunSel), .rfRSel(rfRSel), .arfRegSel(arfRegSel), .aluFunSel(aluFunSel),
        .arfOutDSel(arfOutDSel), .muxASel(muxASel), .muxBSel(muxBSel), .irLH(irLH),
        .irEnable(irEnable), .memWrite(memWrite)
    );

endmodule

/* cpuControlAssertions.sv */
`timescale 1ns/1ps
module cpuControlAssertions (
    input logic                clock,
    input logic                rstN,
    input cpuControlPkg::stepT step,
    input logic                memWrite,
    input logic [3:0]          rfRSel,
    input logic [3:0]          arfRegSel
);

    int failures = 0;

    execAfterFetch: assert property (@(posedge clock) disable iff (!rstN)
        step == cpuControlPkg::StepFetchHigh |=> step == cpuControlPkg::StepExec1)
        else begin
            failures++;
            $error("StepExec1 did not follow StepFetchHigh");
        end

    writeInExec2: assert property (@(posedge clock) disable iff (!rstN)
        memWrite |-> step == cpuControlPkg::StepExec2)
        else begin
            failures++;
            $error("memWrite high outside StepExec2");
        end

    // One register file written per cycle
    singleWrite: assert property (@(posedge clock) disable iff (!rstN)
        rfRSel == cpuControlPkg::RfSelNone || arfRegSel == cpuControlPkg::ArfSelNone)
        else begin
            failures++;
            $error("RF and ARF written in the same cycle");
        end

endmodule

bind controlSequencer cpuControlAssertions i_cpuControlAssertions (
    .clock(clock), .rstN(rstN), .step(step), .memWrite(memWrite),
    .rfRSel(rfRSel), .arfRegSel(arfRegSel)
);

/* cpuControlTb.sv */
`timescale 1ns/1ps
module cpuControlTb;

    localparam int ClockPeriod = 40;
    localparam int Settle = 5; // Sample point after the falling edge
    localparam int NumInstr = 34;

    logic clock = 1'b0;
    logic rstN = 1'b0;
    logic [15:0] irOut = '0;
    logic [3:0] aluFlags = '0;
    logic [2:0] rfOutASel, rfOutBSel;
    logic [3:0] rfRSel, arfRegSel;
    logic irLH, irEnable, memWrite, muxCSel;
    cpuControlPkg::regFunT rfFunSel, arfFunSel, irFunSel;
    cpuControlPkg::aluFunT aluFunSel;
    cpuControlPkg::arfOutT arfOutCSel, arfOutDSel;
    cpuControlPkg::muxASelT muxASel;
    cpuControlPkg::muxBSelT muxBSel;

    int errors = 0;
    int checks = 0;
    string testName = "";
    logic [31:0] rngState = 32'd94739;

    // ALU group opcodes and the ALU function each one selects
    cpuControlPkg::opcodeT aluOps [8] = '{cpuControlPkg::OpAnd, cpuControlPkg::OpOr,
        cpuControlPkg::OpNot, cpuControlPkg::OpAdd, cpuControlPkg::OpSub,
        cpuControlPkg::OpLsr, cpuControlPkg::OpLsl, cpuControlPkg::OpMov};
    cpuControlPkg::aluFunT aluFuns [8] = '{cpuControlPkg::AluAnd, cpuControlPkg::AluOr,
        cpuControlPkg::AluNot, cpuControlPkg::AluAdd, cpuControlPkg::AluSub,
        cpuControlPkg::AluLsr, cpuControlPkg::AluLsl, cpuControlPkg::AluPassA};
    cpuControlPkg::arfOutT arfCodes [4] = '{cpuControlPkg::ArfSp, cpuControlPkg::ArfAr,
                                            cpuControlPkg::ArfPc, cpuControlPkg::ArfPc};
    logic [3:0] arfOneHot [4] = '{4'b0010, 4'b0100, 4'b1000, 4'b1000}; // SP, AR, PC, PC
    logic [3:0] rfOneHot [4] = '{4'b1000, 4'b0100, 4'b0010, 4'b0001}; // R1 to R4

    cpuControl i_cpuControl (.*);

    always #(ClockPeriod / 2) clock = ~clock;

    initial begin
        #((NumInstr * 4 + 20) * ClockPeriod);
        $display("Watchdog expired before the tests finished");
        $display("*** TEST FAILED ***");
        $finish;
    end

    function automatic logic [31:0] xorshift();
        rngState ^= rngState << 13;
        rngState ^= rngState >> 17;
        rngState ^= rngState << 5;
        return rngState;
    endfunction

    task automatic tally(input bit ok, input string what, input string exp, input string act);
        checks++;
        if (!ok) begin
            errors++;
            $display("Fail %s %s: expected %s, actual %s", testName, what, exp, act);
        end
    endtask

    task automatic checkAluFun(input string what, input cpuControlPkg::aluFunT exp, act);
        tally(act === exp, what, exp.name(), act.name());
    endtask
    task automatic checkMuxA(input string what, input cpuControlPkg::muxASelT exp, act);
        tally(act === exp, what, exp.name(), act.name());
    endtask
    task automatic checkMuxB(input string what, input cpuControlPkg::muxBSelT exp, act);
        tally(act === exp, what, exp.name(), act.name());
    endtask
    task automatic checkArfOut(input string what, input cpuControlPkg::arfOutT exp, act);
        tally(act === exp, what, exp.name(), act.name());
    endtask
    task automatic checkRegFun(input string what, input cpuControlPkg::regFunT exp, act);
        tally(act === exp, what, exp.name(), act.name());
    endtask
    task automatic checkSel(input string what, input logic [3:0] exp, act);
        tally(act === exp, what, $sformatf("%b", exp), $sformatf("%b", act));
    endtask
    task automatic checkRfOut(input string what, input logic [2:0] exp, act);
        tally(act === exp, what, $sformatf("%b", exp), $sformatf("%b", act));
    endtask
    task automatic checkBit(input string what, input logic exp, act);
        tally(act === exp, what, $sformatf("%b", exp), $sformatf("%b", act));
    endtask

    task automatic nextStep();
        @(negedge clock);
        #Settle;
    endtask

    task automatic checkFetch(input logic high);
        checkBit("irEnable", 1'b1, irEnable);
        checkBit("irLH", high, irLH);
        checkRegFun("irFunSel", cpuControlPkg::FunLoad, irFunSel);
        checkArfOut("arfOutDSel", cpuControlPkg::ArfPc, arfOutDSel);
        checkRegFun("arfFunSel", cpuControlPkg::FunInc, arfFunSel);
        checkSel("arfRegSel", 4'b1000, arfRegSel);
        checkSel("rfRSel", cpuControlPkg::RfSelNone, rfRSel);
        checkBit("memWrite", 1'b0, memWrite);
    endtask

    task automatic checkExec(input logic [3:0] rfExp, arfExp, input logic memExp);
        checkSel("rfRSel", rfExp, rfRSel);
        checkSel("arfRegSel", arfExp, arfRegSel);
        checkBit("memWrite", memExp, memWrite);
        checkBit("irEnable", 1'b0, irEnable);
    endtask

    // Called on a falling edge in StepFetchLow, returns settled in StepExec1
    task automatic fetchInstr(input logic [15:0] word);
        irOut = word;
        #Settle;
        checkFetch(1'b0);
        nextStep();
        checkFetch(1'b1);
        nextStep();
    endtask

    task automatic aluInstr(input logic [2:0] k, input logic [3:0] dst, a, b);
        fetchInstr({aluOps[k], dst, a, b});
        checkAluFun("aluFunSel", aluFuns[k], aluFunSel);
        checkBit("muxCSel", a[2], muxCSel); // Codes 4 to 7 live in the ARF
        if (a[2]) begin
            checkArfOut("arfOutCSel", arfCodes[a[1:0]], arfOutCSel);
        end else begin
            checkRfOut("rfOutASel", {1'b1, a[1:0]}, rfOutASel);
        end
        if (!b[2]) begin
            checkRfOut("rfOutBSel", {1'b1, b[1:0]}, rfOutBSel);
        end
        if (dst[2]) begin
            checkExec(cpuControlPkg::RfSelNone, arfOneHot[dst[1:0]], 1'b0);
            checkMuxB("muxBSel", cpuControlPkg::MuxBAlu, muxBSel);
            checkRegFun("arfFunSel", cpuControlPkg::FunLoad, arfFunSel);
        end else begin
            checkExec(rfOneHot[dst[1:0]], cpuControlPkg::ArfSelNone, 1'b0);
            checkMuxA("muxASel", cpuControlPkg::MuxAAlu, muxASel);
            checkRegFun("rfFunSel", cpuControlPkg::FunLoad, rfFunSel);
        end
        @(negedge clock);
    endtask

    task automatic branchInstr(input cpuControlPkg::opcodeT op, input logic direct);
        fetchInstr({op, 1'b0, direct, 10'h0a5});
        checkMuxB("muxBSel", cpuControlPkg::MuxBIrAddr, muxBSel);
        checkExec(cpuControlPkg::RfSelNone, direct ? 4'b0100 : 4'b1000, 1'b0);
        if (direct) begin
            nextStep(); // PC from memory at AR
            checkArfOut("arfOutDSel", cpuControlPkg::ArfAr, arfOutDSel);
            checkMuxB("muxBSel", cpuControlPkg::MuxBMem, muxBSel);
            checkExec(cpuControlPkg::RfSelNone, 4'b1000, 1'b0);
        end
        @(negedge clock);
    endtask

    task automatic noWriteInstr(input logic [15:0] word);
        fetchInstr(word);
        checkExec(cpuControlPkg::RfSelNone, cpuControlPkg::ArfSelNone, 1'b0);
        checkBit("muxCSel", 1'b0, muxCSel); // No ARF source read
        @(negedge clock);
    endtask

    task automatic ldInstr(input logic direct, input logic [1:0] r);
        fetchInstr({cpuControlPkg::OpLd, 1'b0, direct, r, 8'h5a});
        if (direct) begin
            checkMuxB("muxBSel", cpuControlPkg::MuxBIrAddr, muxBSel);
            checkExec(cpuControlPkg::RfSelNone, 4'b0100, 1'b0);
            nextStep();
            checkArfOut("arfOutDSel", cpuControlPkg::ArfAr, arfOutDSel);
            checkMuxA("muxASel", cpuControlPkg::MuxAMem, muxASel);
        end else begin
            checkMuxA("muxASel", cpuControlPkg::MuxAIrAddr, muxASel);
        end
        checkRegFun("rfFunSel", cpuControlPkg::FunLoad, rfFunSel);
        checkExec(rfOneHot[r], cpuControlPkg::ArfSelNone, 1'b0);
        @(negedge clock);
    endtask

    task automatic stInstr(input logic mode, input logic [1:0] r);
        fetchInstr({cpuControlPkg::OpSt, 1'b0, mode, r, 8'hc3});
        checkMuxB("muxBSel", cpuControlPkg::MuxBIrAddr, muxBSel);
        checkExec(cpuControlPkg::RfSelNone, 4'b0100, 1'b0);
        nextStep();
        checkArfOut("arfOutDSel", cpuControlPkg::ArfAr, arfOutDSel);
        checkAluFun("aluFunSel", cpuControlPkg::AluPassB, aluFunSel);
        checkRfOut("rfOutBSel", {1'b1, r}, rfOutBSel);
        checkExec(cpuControlPkg::RfSelNone, cpuControlPkg::ArfSelNone, 1'b1);
        @(negedge clock);
    endtask

    task automatic testReset();
        testName = "reset";
        repeat (7) @(negedge clock);
        #Settle;
        checkFetch(1'b0);
        @(negedge clock);
        rstN = 1'b1;
        aluInstr(3'd7, 4'd1, 4'd0, 4'd2); // MOV into R2 from R1
    endtask

    task automatic testRandomAlu();
        logic [31:0] r;
        testName = "randomAlu";
        repeat (20) begin
            r = xorshift();
            aluInstr(r[2:0], {1'b0, r[6:4]}, {1'b0, r[10:8]}, {1'b0, r[14:12]});
        end
    endtask

    task automatic testBra();
        testName = "bra";
        branchInstr(cpuControlPkg::OpBra, 1'b0);
        branchInstr(cpuControlPkg::OpBra, 1'b1);
    endtask

    task automatic testBne();
        testName = "bneTaken";
        aluFlags = 4'b1110; // Only the zero flag clear
        branchInstr(cpuControlPkg::OpBne, 1'b0);
        branchInstr(cpuControlPkg::OpBne, 1'b1);
        testName = "bneNotTaken";
        aluFlags = 4'b0001;
        noWriteInstr({cpuControlPkg::OpBne, 12'h4a5}); // Direct bit set but no AR load
        aluFlags = 4'b0000;
    endtask

    task automatic testLoadStore();
        testName = "ld";
        ldInstr(1'b0, 2'd2);
        ldInstr(1'b1, 2'd3);
        testName = "st";
        stInstr(1'b0, 2'd1);
        stInstr(1'b1, 2'd0);
    endtask

    task automatic testDropped();
        testName = "dropped";
        noWriteInstr({cpuControlPkg::OpInc, 12'h567});
        noWriteInstr({cpuControlPkg::OpDec, 12'h476});
        noWriteInstr({cpuControlPkg::OpPush, 12'h745});
        noWriteInstr({cpuControlPkg::OpPull, 12'h654});
    endtask

    initial begin
        testReset();
        testRandomAlu();
        testBra();
        testBne();
        testLoadStore();
        testDropped();
        testName = "final";
        #Settle;
        checkFetch(1'b0);
        errors += i_cpuControl.i_controlSequencer.i_cpuControlAssertions.failures;
        $display("Checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("*** TEST PASSED ***");
        end else begin
            $display("*** TEST FAILED ***");
        end
        $finish;
    end

endmodule

/* project.f */
cpuControlPkg.sv
instructionDecoder.sv
registerSelect.sv
controlSequencer.sv
cpuControl.sv
cpuControlAssertions.sv
cpuControlTb.sv

/* Makefile */
SIM      = verilator
FLAGS    = --binary --timing --assert -j 0
TOP      = cpuControlTb
FILELIST = project.f

SOURCES  = $(shell grep -v '^+' $(FILELIST))
BIN      = obj_dir/V$(TOP)

.PHONY: all run clean

all: $(BIN)

$(BIN): $(SOURCES) $(FILELIST)
	$(SIM) $(FLAGS) --top-module $(TOP) -f $(FILELIST)

run: $(BIN)
	out=$$(./$(BIN)); echo "$$out"; echo "$$out" | grep -qF '*** TEST PASSED ***'

clean:
	rm -rf obj_dir
